// ==== hdl/apu_reg_pkg.sv ====
package apu_reg_pkg;

	// low address bytes of the channel 3 registers
	localparam logic [7:0] NR30_ADDR = 8'h1a; // dac power
	localparam logic [7:0] NR31_ADDR = 8'h1b; // length load
	localparam logic [7:0] NR32_ADDR = 8'h1c; // output level
	localparam logic [7:0] NR33_ADDR = 8'h1d; // freq low byte
	localparam logic [7:0] NR34_ADDR = 8'h1e; // trigger, len enable, freq high

	localparam logic [7:0] WAVE_BASE = 8'h30; // wave ram 30..3f

	localparam int DAC_EN_BIT  = 7;
	localparam int VOL_LSB     = 5;
	localparam int VOL_MSB     = 6;
	localparam int LEN_EN_BIT  = 6;
	localparam int TRIG_BIT    = 7;
	localparam int FREQ_HI_MSB = 2; // nr34 2:0 carry freq 10:8

	// bits that always read back as one
	localparam logic [7:0] NR30_RMASK = 8'h7f;
	localparam logic [7:0] NR32_RMASK = 8'h9f;
	localparam logic [7:0] NR34_RMASK = 8'hbf;

	localparam logic [7:0] OPEN_BUS = 8'hff; // nr31, nr33 and unmapped

endpackage

// ==== hdl/wave_pkg.sv ====
package wave_pkg;

	localparam int SAMPLE_W   = 4;
	localparam int POS_W      = 5; // 32 samples
	localparam int INDEX_W    = POS_W - 1; // byte index holding two samples
	localparam int WAVE_BYTES = 16;
	localparam int FREQ_W     = 11;
	localparam int TIMER_W    = FREQ_W + 1; // must hold 2048
	localparam int LEN_W      = 9; // counts up to 256

	typedef enum logic [1:0] {
		VOL_MUTE    = 2'b00, // shift 4
		VOL_FULL    = 2'b01, // shift 0
		VOL_HALF    = 2'b10, // shift 1
		VOL_QUARTER = 2'b11  // shift 2
	} vol_code_t;

	// cpu sees a byte, playback sees two samples
	typedef union packed {
		logic [2*SAMPLE_W-1:0] bits;
		struct packed {
			logic [SAMPLE_W-1:0] hi; // played first
			logic [SAMPLE_W-1:0] lo;
		} nib;
	} wave_byte_u;

endpackage

// ==== hdl/ch3_ctrl_if.sv ====
`timescale 1ns/1ps

interface ch3_ctrl_if;

	logic                        dac_en;
	logic                        len_en;
	logic                        len_load; // one cycle pulse
	logic [wave_pkg::LEN_W-2:0]  len_value;
	wave_pkg::vol_code_t         volume;
	logic [wave_pkg::FREQ_W-1:0] freq;
	logic                        trigger; // one cycle pulse

	modport decode (
		output dac_en, len_en, len_load, len_value, volume, freq, trigger
	);

	modport execute (
		input dac_en, len_en, len_load, len_value, freq, trigger
	);

	modport result (
		input volume
	);

endinterface

// ==== hdl/ch3_reg_decode.sv ====
`timescale 1ns/1ps

module ch3_reg_decode (
	input  logic                 cery_2mhz,
	input  logic                 rst_n,
	input  logic                 wr,
	input  logic                 rd,
	input  logic [7:0]           addr,
	input  logic [7:0]           wdata,
	input  logic                 ch3_active,
	input  wave_pkg::wave_byte_u ram_rdata,
	ch3_ctrl_if.decode           ctrl,
	output logic                 ram_we,
	output logic [7:0]           rdata
);

	logic                        dac_en;
	logic [wave_pkg::LEN_W-2:0]  len_value;
	wave_pkg::vol_code_t         volume;
	logic [wave_pkg::FREQ_W-1:0] freq;
	logic                        len_en;
	logic                        trigger;
	logic                        len_load;
	logic                        wave_sel;

	assign wave_sel = addr[7:4] == apu_reg_pkg::WAVE_BASE[7:4];
	assign ram_we   = wr && wave_sel && !ch3_active; // locked while playing

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			dac_en    <= 1'b0;
			len_value <= '0;
			volume    <= wave_pkg::VOL_MUTE;
			freq      <= '0;
			len_en    <= 1'b0;
			trigger   <= 1'b0;
			len_load  <= 1'b0;
		end else begin
			trigger  <= 1'b0;
			len_load <= 1'b0;
			if (wr) begin
				case (addr)
					apu_reg_pkg::NR30_ADDR: dac_en <= wdata[apu_reg_pkg::DAC_EN_BIT];
					apu_reg_pkg::NR31_ADDR: begin
						len_value <= wdata;
						len_load  <= 1'b1;
					end
					apu_reg_pkg::NR32_ADDR: begin
						volume <= wave_pkg::vol_code_t'(
							wdata[apu_reg_pkg::VOL_MSB:apu_reg_pkg::VOL_LSB]);
					end
					apu_reg_pkg::NR33_ADDR: freq[7:0] <= wdata;
					apu_reg_pkg::NR34_ADDR: begin
						freq[wave_pkg::FREQ_W-1:8] <= wdata[apu_reg_pkg::FREQ_HI_MSB:0];
						len_en  <= wdata[apu_reg_pkg::LEN_EN_BIT];
						trigger <= wdata[apu_reg_pkg::TRIG_BIT]; // write-only bit
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rdata = 8'h00;
		if (rd) begin
			if (wave_sel) begin
				rdata = ram_rdata.bits; // ram already muxes in the playing byte
			end else begin
				case (addr)
					apu_reg_pkg::NR30_ADDR:
						rdata = apu_reg_pkg::NR30_RMASK | (8'(dac_en) << apu_reg_pkg::DAC_EN_BIT);
					apu_reg_pkg::NR32_ADDR:
						rdata = apu_reg_pkg::NR32_RMASK | (8'(volume) << apu_reg_pkg::VOL_LSB);
					apu_reg_pkg::NR34_ADDR:
						rdata = apu_reg_pkg::NR34_RMASK | (8'(len_en) << apu_reg_pkg::LEN_EN_BIT);
					default:
						rdata = apu_reg_pkg::OPEN_BUS;
				endcase
			end
		end
	end

	assign ctrl.dac_en    = dac_en;
	assign ctrl.len_en    = len_en;
	assign ctrl.len_load  = len_load;
	assign ctrl.len_value = len_value;
	assign ctrl.volume    = volume;
	assign ctrl.freq      = freq;
	assign ctrl.trigger   = trigger;

endmodule

// ==== hdl/ch3_wave_ram.sv ====
`timescale 1ns/1ps

module ch3_wave_ram (
	input  logic                         cery_2mhz,
	input  logic                         ram_we,
	input  logic [wave_pkg::INDEX_W-1:0] addr,
	input  logic [7:0]                   wdata,
	output wave_pkg::wave_byte_u         cpu_rdata,
	input  logic [wave_pkg::INDEX_W-1:0] play_index,
	input  logic                         ch3_active,
	output wave_pkg::wave_byte_u         play_byte
);

	wave_pkg::wave_byte_u mem [wave_pkg::WAVE_BYTES];

	logic [wave_pkg::INDEX_W-1:0] cpu_index;

	always_ff @(posedge cery_2mhz) begin
		if (ram_we) begin
			mem[addr].bits <= wdata;
		end
	end

	// while playing the cpu address is replaced by the play pointer
	assign cpu_index = ch3_active ? play_index : addr;

	assign cpu_rdata = mem[cpu_index];
	assign play_byte = mem[play_index];

endmodule

// ==== hdl/ch3_wave_sequencer.sv ====
`timescale 1ns/1ps

module ch3_wave_sequencer (
	input  logic                         cery_2mhz,
	input  logic                         rst_n,
	input  logic                         frame_256hz,
	ch3_ctrl_if.execute                  ctrl,
	output logic [wave_pkg::INDEX_W-1:0] play_index,
	output logic                         nibble_sel,
	output logic                         ch3_active,
	output logic                         step
);

	logic [wave_pkg::TIMER_W-1:0] period;
	logic [wave_pkg::TIMER_W-1:0] timer;
	logic [wave_pkg::POS_W-1:0]   pos;
	logic [wave_pkg::LEN_W-1:0]   len_cnt;
	logic                         timer_wrap;
	logic                         len_done;

	// cycles per sample is 2048 - freq
	assign period = {1'b1, {wave_pkg::FREQ_W{1'b0}}} - {1'b0, ctrl.freq};

	assign timer_wrap = timer == {{(wave_pkg::TIMER_W-1){1'b0}}, 1'b1};
	assign len_done   = len_cnt[wave_pkg::LEN_W-1]; // reached 256

	// frequency timer and sample position
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			timer <= '0;
			pos   <= '0;
			step  <= 1'b0;
		end else begin
			step <= ctrl.trigger || (ch3_active && timer_wrap);
			if (ctrl.trigger) begin
				timer <= period;
				pos   <= '0;
			end else if (ch3_active) begin
				if (timer_wrap) begin
					timer <= period; // freq changes apply on reload
					pos   <= pos + 1'b1;
				end else begin
					timer <= timer - 1'b1;
				end
			end
		end
	end

	// length counter saturating at 256
	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			len_cnt <= '0;
		end else if (ctrl.len_load) begin
			len_cnt <= {1'b0, ctrl.len_value};
		end else if (ctrl.trigger && len_done) begin
			len_cnt <= '0;
		end else if (frame_256hz && ctrl.len_en && !len_done) begin
			len_cnt <= len_cnt + 1'b1;
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			ch3_active <= 1'b0;
		end else if (!ctrl.dac_en) begin
			ch3_active <= 1'b0; // dac power off wins over trigger
		end else if (ctrl.trigger) begin
			ch3_active <= 1'b1;
		end else if (ctrl.len_en && len_done) begin
			ch3_active <= 1'b0;
		end
	end

	assign play_index = pos[wave_pkg::POS_W-1:1];
	assign nibble_sel = pos[0]; // odd sample is the low nibble

endmodule

// ==== hdl/ch3_volume_dac.sv ====
`timescale 1ns/1ps

module ch3_volume_dac (
	input  logic                          cery_2mhz,
	input  logic                          rst_n,
	ch3_ctrl_if.result                    ctrl,
	input  wave_pkg::wave_byte_u          play_byte,
	input  logic                          nibble_sel,
	input  logic                          ch3_active,
	input  logic                          step,
	output logic [wave_pkg::SAMPLE_W-1:0] wave_dac_d
);

	logic [wave_pkg::SAMPLE_W-1:0] sample;
	logic [wave_pkg::SAMPLE_W-1:0] level;
	logic [wave_pkg::SAMPLE_W-1:0] dac_q;

	assign sample = nibble_sel ? play_byte.nib.lo : play_byte.nib.hi;

	always_comb begin
		case (ctrl.volume)
			wave_pkg::VOL_FULL:    level = sample;
			wave_pkg::VOL_HALF:    level = sample >> 1;
			wave_pkg::VOL_QUARTER: level = sample >> 2;
			default:               level = '0; // mute
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			dac_q <= '0;
		end else if (!ch3_active) begin
			dac_q <= '0;
		end else if (step) begin
			dac_q <= level;
		end
	end

	assign wave_dac_d = ch3_active ? dac_q : '0; // silent the moment the channel stops

endmodule

// ==== hdl/ch3_wave_channel.sv ====
`timescale 1ns/1ps

module ch3_wave_channel (
	input  logic                          cery_2mhz,
	input  logic                          rst_n,
	input  logic                          wr,
	input  logic                          rd,
	input  logic [7:0]                    addr,
	input  logic [7:0]                    wdata,
	output logic [7:0]                    rdata,
	input  logic                          frame_256hz,
	output logic                          ch3_active,
	output logic [wave_pkg::SAMPLE_W-1:0] wave_dac_d
);

	logic                         ram_we;
	wave_pkg::wave_byte_u         ram_rdata;
	wave_pkg::wave_byte_u         play_byte;
	logic [wave_pkg::INDEX_W-1:0] play_index;
	logic                         nibble_sel;
	logic                         step;

	ch3_ctrl_if ctrl_bus ();

	ch3_reg_decode ch3_reg_decode_inst (
		.cery_2mhz (cery_2mhz),
		.rst_n     (rst_n),
		.wr        (wr),
		.rd        (rd),
		.addr      (addr),
		.wdata     (wdata),
		.ch3_active(ch3_active),
		.ram_rdata (ram_rdata),
		.ctrl      (ctrl_bus.decode),
		.ram_we    (ram_we),
		.rdata     (rdata)
	);

	ch3_wave_ram ch3_wave_ram_inst (
		.cery_2mhz (cery_2mhz),
		.ram_we    (ram_we),
		.addr      (addr[wave_pkg::INDEX_W-1:0]),
		.wdata     (wdata),
		.cpu_rdata (ram_rdata),
		.play_index(play_index),
		.ch3_active(ch3_active),
		.play_byte (play_byte)
	);

	ch3_wave_sequencer ch3_wave_sequencer_inst (
		.cery_2mhz  (cery_2mhz),
		.rst_n      (rst_n),
		.frame_256hz(frame_256hz),
		.ctrl       (ctrl_bus.execute),
		.play_index (play_index),
		.nibble_sel (nibble_sel),
		.ch3_active (ch3_active),
		.step       (step)
	);

	ch3_volume_dac ch3_volume_dac_inst (
		.cery_2mhz (cery_2mhz),
		.rst_n     (rst_n),
		.ctrl      (ctrl_bus.result),
		.play_byte (play_byte),
		.nibble_sel(nibble_sel),
		.ch3_active(ch3_active),
		.step      (step),
		.wave_dac_d(wave_dac_d)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic cery_2mhz,
	output logic rst_n
);

	localparam int RESET_CYCLES = 4;

	initial begin
		cery_2mhz = 1'b0;
		forever #50 cery_2mhz = ~cery_2mhz; // 100 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge cery_2mhz);
		rst_n <= 1'b1;
	end

endmodule

// ==== testbench/tb_ch3_wave_channel.sv ====
`timescale 1ns/1ps

module tb_ch3_wave_channel;

	localparam int MAX_PERIOD     = 16;
	localparam int SETUP_CYCLES   = 400;
	localparam int PLAY_CYCLES    = 4 * (32 * MAX_PERIOD + 40);
	localparam int LEN_CYCLES     = 3 * (64 + 300) + 40;
	localparam int TIMEOUT_CYCLES = SETUP_CYCLES + PLAY_CYCLES + LEN_CYCLES + 500;

	logic       cery_2mhz;
	logic       rst_n;
	logic       wr;
	logic       rd;
	logic [7:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       frame_256hz;
	logic       ch3_active;
	logic [3:0] wave_dac_d;

	logic [7:0] wave_mem [16]; // model of the wave ram
	int         checks;
	int         errors;

	tb_clock_gen tb_clock_gen_inst (
		.cery_2mhz(cery_2mhz),
		.rst_n    (rst_n)
	);

	ch3_wave_channel ch3_wave_channel_inst (
		.cery_2mhz  (cery_2mhz),
		.rst_n      (rst_n),
		.wr         (wr),
		.rd         (rd),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.frame_256hz(frame_256hz),
		.ch3_active (ch3_active),
		.wave_dac_d (wave_dac_d)
	);

	dac_silent_check: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		(ch3_active || wave_dac_d == 4'd0))
	else begin
		errors++;
		$display("CHECK FAILED at %0t: wave_dac_d expected 0, got %0h", $time, wave_dac_d);
	end

	task automatic compare_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %02h, got %02h",
				$time, name, expected, actual);
		end
	endtask

	function automatic logic [3:0] expected_level(input logic [7:0] wave_byte, input int k,
		input logic [1:0] vol);
		logic [3:0] nib;
		int         shift;
		nib = (k % 2 == 0) ? wave_byte[7:4] : wave_byte[3:0]; // even sample is the high nibble
		case (vol)
			2'd0:    shift = 4;
			2'd1:    shift = 0;
			2'd2:    shift = 1;
			default: shift = 2;
		endcase
		return nib >> shift;
	endfunction

	task automatic write_bus(input logic [7:0] a, input logic [7:0] d);
		@(posedge cery_2mhz);
		wr    <= 1'b1;
		rd    <= 1'b0;
		addr  <= a;
		wdata <= d;
		@(posedge cery_2mhz);
		wr <= 1'b0;
	endtask

	task automatic read_and_check(input logic [7:0] a, input logic [7:0] expected);
		logic [7:0] data;
		@(posedge cery_2mhz);
		rd   <= 1'b1;
		addr <= a;
		@(negedge cery_2mhz);
		data = rdata;
		@(posedge cery_2mhz);
		rd <= 1'b0;
		compare_value($sformatf("rdata[%02h]", a), expected, data);
	endtask

	task automatic register_test();
		logic [7:0] value [5];
		int         i;
		for (i = 0; i < 5; i++) begin
			value[i] = 8'($urandom);
		end
		value[4][apu_reg_pkg::TRIG_BIT] = 1'b0; // no trigger here
		write_bus(apu_reg_pkg::NR30_ADDR, value[0]);
		write_bus(apu_reg_pkg::NR31_ADDR, value[1]);
		write_bus(apu_reg_pkg::NR32_ADDR, value[2]);
		write_bus(apu_reg_pkg::NR33_ADDR, value[3]);
		write_bus(apu_reg_pkg::NR34_ADDR, value[4]);
		read_and_check(apu_reg_pkg::NR30_ADDR, value[0] | apu_reg_pkg::NR30_RMASK);
		read_and_check(apu_reg_pkg::NR31_ADDR, 8'hff);
		read_and_check(apu_reg_pkg::NR32_ADDR, value[2] | apu_reg_pkg::NR32_RMASK);
		read_and_check(apu_reg_pkg::NR33_ADDR, 8'hff);
		read_and_check(apu_reg_pkg::NR34_ADDR, value[4] | apu_reg_pkg::NR34_RMASK);
		read_and_check(8'h10, 8'hff); // unmapped
		read_and_check(8'h1f, 8'hff);
		read_and_check(8'h27, 8'hff);
		read_and_check(8'h40, 8'hff);
		read_and_check(8'hff, 8'hff);
	endtask

	task automatic wave_ram_fill();
		int i;
		for (i = 0; i < 16; i++) begin
			wave_mem[i] = 8'($urandom);
			write_bus({4'h3, 4'(i)}, wave_mem[i]);
		end
	endtask

	task automatic wave_ram_verify();
		int i;
		for (i = 0; i < 16; i++) begin
			read_and_check({4'h3, 4'(i)}, wave_mem[i]);
		end
	endtask

	task automatic start_channel(input logic [10:0] freq, input bit len_en);
		write_bus(apu_reg_pkg::NR33_ADDR, freq[7:0]);
		write_bus(apu_reg_pkg::NR34_ADDR, {1'b1, len_en, 3'b000, freq[10:8]});
	endtask

	task automatic check_rise(input logic [7:0] expected);
		@(negedge cery_2mhz);
		compare_value("ch3_active", 8'h00, {7'b0, ch3_active}); // trigger still in flight
		@(negedge cery_2mhz);
		compare_value("ch3_active", expected, {7'b0, ch3_active});
		compare_value("wave_dac_d", 8'h00, {4'h0, wave_dac_d}); // first sample one cycle later
	endtask

	task automatic stop_channel();
		write_bus(apu_reg_pkg::NR30_ADDR, 8'h00);
		@(negedge cery_2mhz);
		compare_value("ch3_active", 8'h01, {7'b0, ch3_active});
		@(negedge cery_2mhz);
		compare_value("ch3_active", 8'h00, {7'b0, ch3_active});
	endtask

	task automatic play_and_check(input logic [1:0] vol, input int period, input bit poke);
		int c;
		int k;
		int idx;
		write_bus(apu_reg_pkg::NR30_ADDR, 8'h80);
		write_bus(apu_reg_pkg::NR32_ADDR, {1'b0, vol, 5'b00000});
		start_channel(11'(2048 - period), 1'b0);
		check_rise(8'h01);
		for (c = 0; c < 32 * period; c++) begin
			@(posedge cery_2mhz);
			k   = c / period;
			idx = (poke && c == 3) ? 5 : int'($urandom % 16);
			rd    <= (c % period == 0) && (k % 4 == 1);
			wr    <= poke && (c == 3); // ignored while playing
			addr  <= {4'h3, 4'(idx)};
			wdata <= ~wave_mem[idx];
			@(negedge cery_2mhz);
			compare_value("wave_dac_d", {4'h0, expected_level(wave_mem[k / 2], k, vol)},
				{4'h0, wave_dac_d});
			if (rd) begin
				compare_value("rdata", wave_mem[k / 2], rdata);
			end
		end
		stop_channel();
	endtask

	task automatic frame_pulse();
		@(posedge cery_2mhz);
		frame_256hz <= 1'b1;
		@(posedge cery_2mhz);
		frame_256hz <= 1'b0;
		@(posedge cery_2mhz);
		@(negedge cery_2mhz);
	endtask

	task automatic length_test();
		logic [7:0] len_start;
		int         pulses;
		int         n;
		len_start = 8'(230 + $urandom % 20);
		pulses    = 256 - int'(len_start);
		write_bus(apu_reg_pkg::NR30_ADDR, 8'h80);
		write_bus(apu_reg_pkg::NR31_ADDR, len_start);
		start_channel(11'd2038, 1'b1);
		check_rise(8'h01);
		for (n = 1; n <= pulses; n++) begin
			frame_pulse();
			compare_value("ch3_active", (n < pulses) ? 8'h01 : 8'h00, {7'b0, ch3_active});
		end
		start_channel(11'd2038, 1'b0); // length off
		check_rise(8'h01);
		for (n = 1; n <= 300; n++) begin
			frame_pulse();
			compare_value("ch3_active", 8'h01, {7'b0, ch3_active});
		end
		stop_channel();
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge cery_2mhz);
		$display("watchdog: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'hb4347f04));
		checks      = 0;
		errors      = 0;
		wr          = 1'b0;
		rd          = 1'b0;
		addr        = 8'h00;
		wdata       = 8'h00;
		frame_256hz = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge cery_2mhz);
		compare_value("ch3_active", 8'h00, {7'b0, ch3_active});
		compare_value("wave_dac_d", 8'h00, {4'h0, wave_dac_d});
		register_test();
		wave_ram_fill();
		wave_ram_verify();
		play_and_check(2'd1, 12, 1'b1); // full volume plus a write while playing
		play_and_check(2'd2, 9, 1'b0);
		play_and_check(2'd3, MAX_PERIOD, 1'b0);
		play_and_check(2'd0, 7, 1'b0);
		wave_ram_verify();
		start_channel(11'd2040, 1'b0); // dac still off
		check_rise(8'h00);
		length_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== wave_channel.f ====
hdl/apu_reg_pkg.sv
hdl/wave_pkg.sv
hdl/ch3_ctrl_if.sv
hdl/ch3_reg_decode.sv
hdl/ch3_wave_ram.sv
hdl/ch3_wave_sequencer.sv
hdl/ch3_volume_dac.sv
hdl/ch3_wave_channel.sv
testbench/tb_clock_gen.sv
testbench/tb_ch3_wave_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the channel 3 testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ch3_wave_channel -Mdir obj_dir -f wave_channel.f; then
	echo "verilator compile failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ch3_wave_channel); then
	echo "$sim_out"
	echo "simulation exited with an error"
	exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
	exit 0
fi
exit 1
